/* attr_interp.f */
+incdir+dv
source/attr_interp_pkg.sv
source/plane_eval.sv
source/pixel_flow_ctrl.sv
source/attr_interp.sv
dv/tb_attr_interp.sv

/* dv/tb_attr_interp_ref.svh */
// Attribute interpolator reference model
// Expected output pixel from the plane rule, and the queue of expected
// pixels that links the input driver to the output checker

`ifndef TB_ATTR_INTERP_REF_SVH
`define TB_ATTR_INTERP_REF_SVH

// Expected pixels in acceptance order
pixel_out_t expected_q [$];

// Each plane is evaluated in 64 bits and only then cut down to 32,
// which gives the modulo 2^32 wrap of the Q16.16 result
function automatic pixel_out_t ref_pixel(input pixel_in_t px, input plane_t pl [NUM_PLANES]);
    pixel_out_t res;
    longint     acc;
    res.side = px.side;
    for (int p = 0; p < NUM_PLANES; p++) begin
        acc = longint'(pl[p].base)
            + longint'(pl[p].inc_x) * longint'(px.x)
            + longint'(pl[p].inc_y) * longint'(px.y);
        res.attrs[p] = attr_t'(acc[ATTR_W-1:0]);
    end
    return res;
endfunction

function automatic void push_expected(input pixel_out_t px);
    expected_q.push_back(px);
endfunction

function automatic pixel_out_t pop_expected();
    return expected_q.pop_front();
endfunction

function automatic int expected_depth();
    return expected_q.size();
endfunction

`endif

/* dv/tb_attr_interp.sv */
// Attribute interpolator testbench
// Streams pixels through the DUT with and without back-pressure, swaps
// triangle coefficients between bursts and checks every output pixel
// against the reference plane model

`timescale 1ns/1ns
`default_nettype none

module tb_attr_interp;
    import attr_interp_pkg::*;

    `include "tb_attr_interp_ref.svh"

    localparam int PIPE_DEPTH   = 3;
    localparam int CLK_HALF     = 4;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 5;
    localparam int RAND_SEED    = 46912;
    localparam int WAIT_LIMIT   = 200;
    localparam int BURST_LEN    = 24;
    localparam int STALL_LEN    = 60;
    localparam int TRI2_LEN     = 20;

    logic       aclk;
    logic       arst_n;
    logic       in_valid;
    logic       in_ready;
    pixel_in_t  in_pixel;
    logic       out_valid;
    logic       out_ready;
    pixel_out_t out_pixel;
    plane_t     planes [NUM_PLANES];
    logic       busy;

    // Owned by the stimulus process
    int         check_errors;
    int         timeout_errors;
    int         accepted_count;
    logic       random_ready;
    logic       aborted;

    // Owned by the output checker
    int         value_errors;
    int         stall_errors;
    int         output_count;
    int         run_len;
    int         max_run;
    logic       hold_pending;
    pixel_out_t held_pixel;

    attr_interp #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) i_dut (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pixel  (in_pixel),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pixel (out_pixel),
        .planes    (planes),
        .busy      (busy)
    );

    initial begin
        aclk = 1'b0;
        forever #CLK_HALF aclk = ~aclk;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic string attr_name(input int idx);
        case (idx)
            ATTR_TEX_S:   return "tex_s";
            ATTR_TEX_T:   return "tex_t";
            ATTR_DEPTH_W: return "depth_w";
            ATTR_DEPTH_Z: return "depth_z";
            ATTR_COLOR_R: return "color_r";
            ATTR_COLOR_G: return "color_g";
            ATTR_COLOR_B: return "color_b";
            ATTR_COLOR_A: return "color_a";
            default:      return "unknown";
        endcase
    endfunction

    function automatic pixel_in_t make_pixel(input logic [POS_W-1:0] x, input logic [POS_W-1:0] y,
                                             input int idx, input logic last);
        pixel_in_t px;
        px.x             = x;
        px.y             = y;
        px.side.fb_index = FB_INDEX_W'(idx);
        px.side.last     = last;
        return px;
    endfunction

    function automatic pixel_in_t random_pixel(input int idx, input logic last);
        return make_pixel(POS_W'($urandom), POS_W'($urandom), idx, last);
    endfunction

    task automatic random_planes();
        for (int p = 0; p < NUM_PLANES; p++) begin
            planes[p].base  = attr_t'($urandom);
            planes[p].inc_x = attr_t'($urandom);
            planes[p].inc_y = attr_t'($urandom);
        end
    endtask

    // Fractional, negative and wrapping planes with hand-computed results
    task automatic known_planes();
        random_planes();
        planes[ATTR_TEX_S]   = '{32'sh0001_0000, 32'sh0000_8000, -32'sh0000_4000};
        planes[ATTR_COLOR_R] = '{32'sh00FF_0000, -32'sh0001_0000, -32'sh0000_8000};
        planes[ATTR_DEPTH_Z] = '{32'sh7FFF_0000, 32'sh0001_0000, 32'sh0000_0000};
    endtask

    // Holds the pixel until the DUT takes it, then records the expected result
    task automatic send_pixel(input pixel_in_t px, output int waited);
        waited = 0;
        @(posedge aclk);
        #DRIVE_DELAY;
        in_valid = 1'b1;
        in_pixel = px;
        @(negedge aclk);
        while (!in_ready && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge aclk);
        end
        if (in_ready) begin
            push_expected(ref_pixel(px, planes));
            accepted_count++;
        end else begin
            timeout_errors++;
            aborted = 1'b1;
            $display("Timeout: in_ready stayed low for %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic go_idle(input int cycles);
        repeat (cycles) begin
            @(posedge aclk);
            #DRIVE_DELAY;
            in_valid = 1'b0;
        end
    endtask

    // Waits until every accepted pixel has left, then expects an idle pipeline
    task automatic wait_drain();
        int waited;
        waited = 0;
        go_idle(1);
        while (expected_depth() != 0 && waited < WAIT_LIMIT) begin
            @(posedge aclk);
            #DRIVE_DELAY;
            waited++;
        end
        if (expected_depth() != 0) begin
            timeout_errors++;
            aborted = 1'b1;
            $display("Timeout: pipeline did not drain, %0d pixels still expected",
                     expected_depth());
        end else begin
            @(negedge aclk);
            assert (!busy) else begin
                check_errors++;
                $display("FAILED %0t: busy still high after the last pixel left", $time);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output side
    //////////////////////////////////////////////////////////////////////

    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge aclk);
            #DRIVE_DELAY;
            if (random_ready) begin
                out_ready = $urandom_range(99, 0) < 60;
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    task automatic check_output(input pixel_out_t got);
        pixel_out_t exp;
        assert (expected_depth() > 0) else begin
            value_errors++;
            $display("Output pixel arrived with no accepted pixel left to match it");
        end
        if (expected_depth() > 0) begin
            exp = pop_expected();
            assert (got.side == exp.side) else begin
                value_errors++;
                $display("FAILED %0t: sideband fb_index %h last %b, expected %h %b", $time,
                         got.side.fb_index, got.side.last, exp.side.fb_index, exp.side.last);
            end
            for (int p = 0; p < NUM_PLANES; p++) begin
                assert (got.attrs[p] == exp.attrs[p]) else begin
                    value_errors++;
                    $display("FAILED %0t: %s got %h expected %h", $time, attr_name(p),
                             got.attrs[p], exp.attrs[p]);
                end
            end
        end
    endtask

    // Samples at the falling edge, where DUT outputs and driven inputs are settled
    initial begin : output_checker
        value_errors = 0;
        stall_errors = 0;
        output_count = 0;
        run_len      = 0;
        max_run      = 0;
        hold_pending = 1'b0;
        held_pixel   = '0;
        forever begin
            @(negedge aclk);
            if (hold_pending) begin
                assert (out_valid && out_pixel == held_pixel) else begin
                    stall_errors++;
                    $display("FAILED %0t: output pixel changed while out_ready was low", $time);
                end
            end
            if (out_valid && out_ready) begin
                check_output(out_pixel);
                output_count++;
                run_len++;
                if (run_len > max_run) begin
                    max_run = run_len;
                end
            end else begin
                run_len = 0;
            end
            hold_pending = out_valid && !out_ready;
            held_pixel   = out_pixel;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        pixel_in_t  px;
        pixel_out_t known;
        int         waited;
        int         stalls;
        void'($urandom(RAND_SEED));
        arst_n         = 1'b0;
        in_valid       = 1'b0;
        in_pixel       = '0;
        random_ready   = 1'b0;
        aborted        = 1'b0;
        check_errors   = 0;
        timeout_errors = 0;
        accepted_count = 0;
        for (int p = 0; p < NUM_PLANES; p++) begin
            planes[p] = '0;
        end
        repeat (RESET_CYCLES) @(posedge aclk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        @(negedge aclk);
        assert (!out_valid && !busy && in_ready) else begin
            check_errors++;
            $display("FAILED %0t: idle outputs wrong after reset", $time);
        end

        // Single pixel, x = 10 and y = 4
        known_planes();
        px    = make_pixel(16'd10, 16'd4, 32'h0000_1234, 1'b1);
        known = ref_pixel(px, planes);
        assert (known.attrs[ATTR_TEX_S] == 32'sh0005_0000
                && known.attrs[ATTR_COLOR_R] == 32'sh00F3_0000
                && known.attrs[ATTR_DEPTH_Z] == 32'sh8009_0000
                && known.side == px.side) else begin
            check_errors++;
            $display("FAILED %0t: reference model disagrees with hand values", $time);
        end
        send_pixel(px, waited);
        wait_drain();

        // Back-to-back burst with the sink always ready
        if (!aborted) begin
            random_planes();
            stalls = 0;
            for (int i = 0; i < BURST_LEN && !aborted; i++) begin
                send_pixel(random_pixel(100 + i, i == BURST_LEN - 1), waited);
                stalls += waited;
            end
            wait_drain();
            assert (stalls == 0 && max_run >= BURST_LEN) else begin
                check_errors++;
                $display("FAILED %0t: burst not streamed one pixel per cycle", $time);
            end
        end

        // Random back-pressure and input gaps
        if (!aborted) begin
            random_ready = 1'b1;
            for (int i = 0; i < STALL_LEN && !aborted; i++) begin
                if ($urandom_range(3, 0) == 0) begin
                    go_idle(1);
                end
                send_pixel(random_pixel(200 + i, i == STALL_LEN - 1), waited);
            end
            wait_drain();
            random_ready = 1'b0;
        end

        // New triangle once the pipeline is empty
        if (!aborted) begin
            @(posedge aclk);
            #DRIVE_DELAY;
            random_planes();
            for (int i = 0; i < TRI2_LEN && !aborted; i++) begin
                send_pixel(random_pixel(300 + i, i == TRI2_LEN - 1), waited);
            end
            wait_drain();
        end

        assert (accepted_count == output_count) else begin
            check_errors++;
            $display("FAILED %0t: %0d pixels accepted but %0d delivered", $time,
                     accepted_count, output_count);
        end

        $display("Errors: value %0d, stall %0d, check %0d, timeout %0d",
                 value_errors, stall_errors, check_errors, timeout_errors);
        if (value_errors + stall_errors + check_errors + timeout_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the attribute interpolator testbench with Verilator and runs it.
# Any build or run failure, and any failing check, ends in a nonzero status.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 -f attr_interp.f \
    --top-module tb_attr_interp -o tb_attr_interp > sim.log 2>&1 &&
    ./obj_dir/tb_attr_interp >> sim.log 2>&1 ||
    echo "tests failed" >> sim.log
cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0

/* source/attr_interp.sv */
// Attribute interpolator top level
// Evaluates all attribute planes of the current triangle for each
// incoming pixel, with a valid/ready stream on both sides and a busy
// flag that guards changes of the triangle coefficients

`timescale 1ns/1ns
`default_nettype none

module attr_interp #(
    parameter int PIPE_DEPTH = 3
) (
    input  wire                          aclk,
    input  wire                          arst_n,

    // Pixel stream in
    input  wire                          in_valid,
    output logic                         in_ready,
    input  attr_interp_pkg::pixel_in_t   in_pixel,

    // Interpolated pixel stream out
    output logic                         out_valid,
    input  wire                          out_ready,
    output attr_interp_pkg::pixel_out_t  out_pixel,

    // Triangle coefficients, static while busy
    input  attr_interp_pkg::plane_t      planes [attr_interp_pkg::NUM_PLANES],

    output logic                         busy
);
    import attr_interp_pkg::*;

    logic                          advance;
    pixel_side_t                   out_side;
    attr_t [NUM_PLANES-1:0]        plane_value;

    //////////////////////////////////////////////////////////////////////
    // Flow control and sideband
    //////////////////////////////////////////////////////////////////////

    pixel_flow_ctrl #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) i_flow_ctrl (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_side   (in_pixel.side),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_side  (out_side),
        .out_ready (out_ready),
        .advance   (advance),
        .busy      (busy)
    );

    //////////////////////////////////////////////////////////////////////
    // One evaluator per attribute plane
    //////////////////////////////////////////////////////////////////////

    // Loop index follows the package attribute order, so plane p
    // lands in attrs[p]
    for (genvar p = 0; p < NUM_PLANES; p++) begin : g_plane
        plane_eval #(
            .PIPE_DEPTH (PIPE_DEPTH)
        ) i_plane (
            .aclk    (aclk),
            .advance (advance),
            .x       (in_pixel.x),
            .y       (in_pixel.y),
            .plane   (planes[p]),
            .value   (plane_value[p])
        );
    end

    // Output pixel assembly
    assign out_pixel.side  = out_side;
    assign out_pixel.attrs = plane_value;

endmodule

`default_nettype wire

/* source/attr_interp_pkg.sv */
// Attribute interpolator shared definitions
// Widths, plane count, attribute order and the packed stream structs
// used by the pixel pipeline and its plane evaluators

`default_nettype none

package attr_interp_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    // Signed Q16.16 attributes and coefficients
    localparam int ATTR_W     = 32;
    // Unsigned integer screen coordinates
    localparam int POS_W      = 16;
    localparam int FB_INDEX_W = 32;
    localparam int NUM_PLANES = 8;

    //////////////////////////////////////////////////////////////////////
    // Attribute order in the output array
    //////////////////////////////////////////////////////////////////////

    localparam int ATTR_TEX_S   = 0;
    localparam int ATTR_TEX_T   = 1;
    localparam int ATTR_DEPTH_W = 2;
    localparam int ATTR_DEPTH_Z = 3;
    localparam int ATTR_COLOR_R = 4;
    localparam int ATTR_COLOR_G = 5;
    localparam int ATTR_COLOR_B = 6;
    localparam int ATTR_COLOR_A = 7;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    typedef logic signed [ATTR_W-1:0] attr_t;

    // One plane, value = base + x * inc_x + y * inc_y
    typedef struct packed {
        attr_t base;
        attr_t inc_x;
        attr_t inc_y;
    } plane_t;

    // Passes through the pipeline untouched
    typedef struct packed {
        logic [FB_INDEX_W-1:0] fb_index;
        logic                  last;
    } pixel_side_t;

    typedef struct packed {
        logic [POS_W-1:0] x;
        logic [POS_W-1:0] y;
        pixel_side_t      side;
    } pixel_in_t;

    typedef struct packed {
        pixel_side_t                side;
        attr_t [NUM_PLANES-1:0]     attrs;
    } pixel_out_t;

endpackage

`default_nettype wire

/* source/pixel_flow_ctrl.sv */
// Pixel pipeline flow control
// Tracks a valid bit and the pass-through sideband per stage, makes the
// single stall decision for all stages and reports pixels in flight

`timescale 1ns/1ns
`default_nettype none

module pixel_flow_ctrl #(
    parameter int PIPE_DEPTH = 3
) (
    input  wire                          aclk,
    input  wire                          arst_n,

    // Upstream side
    input  wire                          in_valid,
    input  attr_interp_pkg::pixel_side_t in_side,
    output logic                         in_ready,

    // Downstream side
    output logic                         out_valid,
    output attr_interp_pkg::pixel_side_t out_side,
    input  wire                          out_ready,

    // Stage enable for every register in the pipeline
    output logic                         advance,
    output logic                         busy
);
    import attr_interp_pkg::*;

    localparam int LAST = PIPE_DEPTH - 1;

    logic [PIPE_DEPTH-1:0] valid_q;
    pixel_side_t           side_q [PIPE_DEPTH];

    //////////////////////////////////////////////////////////////////////
    // Stall decision
    //////////////////////////////////////////////////////////////////////

    // The whole pipeline moves as one. It only stops when the last stage
    // holds a pixel that the sink does not take, so inner bubbles stay
    // where they are during a stall
    assign advance  = !valid_q[LAST] || out_ready;
    assign in_ready = advance;

    //////////////////////////////////////////////////////////////////////
    // Valid bits
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (advance) begin
            // Empty slot enters when the source has nothing
            valid_q[0] <= in_valid;
            for (int s = 1; s < PIPE_DEPTH; s++) begin
                valid_q[s] <= valid_q[s-1];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sideband carry
    //////////////////////////////////////////////////////////////////////

    // Sideband shifts in step with the valid bits
    always_ff @(posedge aclk) begin
        if (advance) begin
            side_q[0] <= in_side;
            for (int s = 1; s < PIPE_DEPTH; s++) begin
                side_q[s] <= side_q[s-1];
            end
        end
    end

    assign out_valid = valid_q[LAST];
    assign out_side  = side_q[LAST];

    // Host may swap triangle coefficients only while this is low
    assign busy = |valid_q;

endmodule

`default_nettype wire

/* source/plane_eval.sv */
// Plane evaluator for one attribute
// Three register stages compute base + x * inc_x + y * inc_y in
// Q16.16, wrapping modulo 2^32

`timescale 1ns/1ns
`default_nettype none

module plane_eval #(
    parameter int PIPE_DEPTH = 3
) (
    input  wire                                 aclk,
    input  wire                                 advance,

    // Screen position shared by all planes
    input  wire [attr_interp_pkg::POS_W-1:0]    x,
    input  wire [attr_interp_pkg::POS_W-1:0]    y,

    input  attr_interp_pkg::plane_t             plane,
    output attr_interp_pkg::attr_t              value
);
    import attr_interp_pkg::*;

    localparam int STAGES = 3;
    localparam int EXT_W  = ATTR_W - POS_W;

    // The flow control must shift exactly as many valid bits as there
    // are data stages here
    if (PIPE_DEPTH != STAGES) begin : g_depth_check
        $error("plane_eval has %0d stages but PIPE_DEPTH is %0d", STAGES, PIPE_DEPTH);
    end

    attr_t x_ext;
    attr_t y_ext;

    attr_t prod_x_q;
    attr_t prod_y_q;
    attr_t step_sum_q;
    attr_t value_q;

    // Coordinates are plain integers, zero extended to attribute width.
    // Integer times Q16.16 stays Q16.16
    assign x_ext = attr_t'({{EXT_W{1'b0}}, x});
    assign y_ext = attr_t'({{EXT_W{1'b0}}, y});

    //////////////////////////////////////////////////////////////////////
    // Stage 1: increments scaled by position
    //////////////////////////////////////////////////////////////////////

    // Only the low 32 bits of each product are kept
    always_ff @(posedge aclk) begin
        if (advance) begin
            prod_x_q <= x_ext * plane.inc_x;
            prod_y_q <= y_ext * plane.inc_y;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 2: total step from the plane origin
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (advance) begin
            step_sum_q <= prod_x_q + prod_y_q;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 3: add the base
    //////////////////////////////////////////////////////////////////////

    // Base is static while pixels are in flight, so it needs no delay
    always_ff @(posedge aclk) begin
        if (advance) begin
            value_q <= step_sum_q + plane.base;
        end
    end

    assign value = value_q;

endmodule

`default_nettype wire
